// File: build.f
+incdir+source
source/ekf_fixed_pkg.sv
source/ekf_io_pkg.sv
source/meas_port.sv
source/result_port.sv
source/ekf_sequencer.sv
source/ekf_predict.sv
source/ekf_correct.sv
source/ekf_top.sv
tests/ekf_properties.sv
tests/tb_ekf.sv

// File: Bender.yml
package:
  name: ekf_soc

sources:
  - include_dirs:
      - source
    files:
      - source/ekf_fixed_pkg.sv
      - source/ekf_io_pkg.sv
      - source/meas_port.sv
      - source/result_port.sv
      - source/ekf_sequencer.sv
      - source/ekf_predict.sv
      - source/ekf_correct.sv
      - source/ekf_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/ekf_properties.sv
      - tests/tb_ekf.sv

// File: tests/tb_ekf.sv
`timescale 1ns/10ps
`include "ekf_config.svh"

module tb_ekf;
    import ekf_fixed_pkg::*;
    import ekf_io_pkg::*;

    localparam int n_rows       = 36;
    localparam int mid_init_row = 28;
    localparam int reset_cycles = 16;
    localparam int step_budget  = 40;
    localparam int ack_hold     = 2;

    typedef struct {
        logic      init;
        current_t  i_b;
        volt_t     v_t;
        int        ack_delay;
        estimate_t expected;
    } row_t;

    logic      clk;
    logic      n_rst;
    logic      meas_req;
    meas_t     meas;
    logic      meas_ack;
    logic      result_req;
    estimate_t result;
    logic      result_ack;

    row_t       rows [n_rows];
    logic [7:0] lfsr;
    logic       seen_short;
    logic       seen_long;
    logic [2:0] seen_band;
    logic       first_long_high;

    ekf_top dut0 (
        .clk        (clk),
        .n_rst      (n_rst),
        .meas_req   (meas_req),
        .meas       (meas),
        .meas_ack   (meas_ack),
        .result_req (result_req),
        .result     (result),
        .result_ack (result_ack)
    );

    bind ekf_top ekf_properties u_properties (
        .clk        (clk),
        .n_rst      (n_rst),
        .meas_req   (meas_req),
        .meas_ack   (meas_ack),
        .result_req (result_req),
        .result     (result)
    );

    always #5 clk = ~clk;

    // --------------------
    // failure and compare tasks
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("mismatch at %0t: %s is %b, expected %b",
                                        $time, name, actual, expected));
        end
    endtask

    task automatic check_estimate(input string name, input estimate_t actual,
                                  input estimate_t expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf(
                "mismatch at %0t: %s is soc %h vrc %h, expected soc %h vrc %h",
                $time, name, actual.soc, actual.vrc, expected.soc, expected.vrc));
        end
    endtask

    // --------------------
    // random ack delays from the taps x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic draw_delay(output int delay);
        delay = 0;
        repeat (4) begin
            lfsr  = lfsr_next(lfsr);
            delay = (delay << 1) | int'(lfsr[0]);
        end
    endtask

    // --------------------
    // reference model
    function automatic longint wrap24(input longint x);
        longint w;
        w = x & 24'hFFFFFF;
        if (w > 8388607) begin
            w = w - 16777216;
        end
        return w;
    endfunction

    task automatic model_step(input logic init, input current_t i_b, input volt_t v_t,
                              inout estimate_t st, output logic short_set, output int band);
        longint soc;
        longint vrc;
        longint i;
        longint b1;
        longint b2;
        longint a4;
        longint rs;
        longint th4;
        longint th5;
        longint soc_p;
        longint vrc_p;
        longint vt;
        longint e;
        i = longint'(i_b);
        soc = init ? longint'(`EKF_INIT_SOC) : longint'(st.soc);
        vrc = init ? longint'(`EKF_INIT_VRC) : longint'(st.vrc);
        short_set = (soc >>> soc_frac) < `EKF_SOC_SET_LIMIT;
        if (short_set) begin
            b1 = `EKF_SET_SHORT_B1;
            b2 = `EKF_SET_SHORT_B2;
            a4 = `EKF_SET_SHORT_A4;
            rs = `EKF_SET_SHORT_RSER;
        end else begin
            b1 = `EKF_SET_LONG_B1;
            b2 = `EKF_SET_LONG_B2;
            a4 = `EKF_SET_LONG_A4;
            rs = `EKF_SET_LONG_RSER;
        end
        soc_p = wrap24(soc + wrap24((b1 * i) >>> (coef_frac - soc_frac)));
        vrc_p = wrap24(wrap24((a4 * vrc) >>> coef_frac)
                     + wrap24((b2 * i) >>> (coef_frac - vrc_frac)));
        // ocv band on the predicted soc
        if ((soc_p >>> soc_frac) < `EKF_OCV_LOW) begin
            band = 0;
            th4  = `EKF_THETA4_LOW;
            th5  = `EKF_THETA5_LOW;
        end else if ((soc_p >>> soc_frac) <= `EKF_OCV_HIGH) begin
            band = 1;
            th4  = `EKF_THETA4_MID;
            th5  = `EKF_THETA5_MID;
        end else begin
            band = 2;
            th4  = `EKF_THETA4_HIGH;
            th5  = `EKF_THETA5_HIGH;
        end
        vt = wrap24(wrap24((th4 * soc_p) >>> (coef_frac + soc_frac - volt_frac))
                  + (th5 >>> (ocv_frac - volt_frac))
                  - (vrc_p >>> (vrc_frac - volt_frac))
                  - wrap24((rs * i) >>> (coef_frac - volt_frac)));
        e = wrap24(longint'(v_t) - vt);
        st.soc = soc_t'(wrap24(soc_p + wrap24((longint'(`EKF_K_SOC) * e) >>> volt_frac)));
        st.vrc = vrc_t'(wrap24(vrc_p + wrap24((longint'(`EKF_K_RC) * e) >>> volt_frac)));
    endtask

    // --------------------
    // stimulus table with expected estimates
    task automatic fill_table();
        estimate_t st;
        logic      short_set;
        int        band;
        st.soc          = `EKF_INIT_SOC;
        st.vrc          = `EKF_INIT_VRC;
        seen_short      = 1'b0;
        seen_long       = 1'b0;
        seen_band       = 3'b000;
        first_long_high = 1'b0;
        for (int k = 0; k < n_rows; k++) begin
            rows[k].init = (k == 0) || (k == mid_init_row);
            if (k == 0) begin
                rows[k].i_b = current_t'(4);
                rows[k].v_t = volt_t'(24'sh3E6666);
            end else if (k < mid_init_row) begin
                // heavy load on a sagging terminal pulls soc down fast
                rows[k].i_b = current_t'(15);
                rows[k].v_t = volt_t'(24'sh040000);
            end else if (k == mid_init_row) begin
                rows[k].i_b = current_t'(2);
                rows[k].v_t = volt_t'(24'sh419999);
            end else begin
                rows[k].i_b = k[0] ? current_t'(3) : current_t'(-2);
                rows[k].v_t = volt_t'(24'sh3CCCCC);
            end
            draw_delay(rows[k].ack_delay);
            model_step(rows[k].init, rows[k].i_b, rows[k].v_t, st, short_set, band);
            rows[k].expected = st;
            seen_short      = seen_short | short_set;
            seen_long       = seen_long | !short_set;
            seen_band[band] = 1'b1;
            if (k == 0) begin
                first_long_high = !short_set && (band == 2);
            end
        end
    endtask

    task automatic drive_row(input int k);
        meas.init = rows[k].init;
        meas.i_b  = rows[k].i_b;
        meas.v_t  = rows[k].v_t;
        meas_req  = 1'b1;
    endtask

    // --------------------
    // main sequence
    initial begin
        int        lat;
        estimate_t held;
        clk        = 1'b0;
        n_rst      = 1'b0;
        meas_req   = 1'b0;
        meas       = '0;
        result_ack = 1'b0;
        lfsr       = 8'd84;
        fill_table();

        repeat (reset_cycles + 4) begin
            @(negedge clk);
            check_flag("meas_ack", meas_ack, 1'b0);
            check_flag("result_req", result_req, 1'b0);
            if (!n_rst && $time >= reset_cycles * 10) begin
                n_rst = 1'b1;
            end
        end

        drive_row(0);
        for (int k = 0; k < n_rows; k++) begin
            do begin
                @(negedge clk);
            end while (!meas_ack);
            check_flag("result_req", result_req, 1'b0);
            meas_req = 1'b0;

            // step latency from ack to req
            lat = 0;
            while (!result_req) begin
                @(negedge clk);
                lat++;
            end
            if (lat != 3) begin
                stop_with_failure($sformatf(
                    "row %0d: result_req rose %0d cycles after meas_ack instead of 3", k, lat));
            end
            check_estimate($sformatf("result of row %0d", k), result, rows[k].expected);
            held = result;

            // next measurement waits behind the open transfer
            if (k + 1 < n_rows) begin
                drive_row(k + 1);
            end
            repeat (rows[k].ack_delay) begin
                @(negedge clk);
                check_flag("meas_ack", meas_ack, 1'b0);
                check_flag("result_req", result_req, 1'b1);
                check_estimate("result", result, held);
            end
            result_ack = 1'b1;
            do begin
                @(negedge clk);
                check_flag("meas_ack", meas_ack, 1'b0);
            end while (result_req);

            // transfer stays open until the sink releases ack
            repeat (ack_hold) begin
                @(negedge clk);
                check_flag("meas_ack", meas_ack, 1'b0);
                check_flag("result_req", result_req, 1'b0);
            end
            result_ack = 1'b0;
        end

        repeat (4) @(negedge clk);
        if (!(seen_short && seen_long && (&seen_band) && first_long_high)) begin
            stop_with_failure("stimulus missed a coefficient set or an OCV band");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

    // hang guard
    initial begin
        repeat (n_rows * step_budget + 200) @(posedge clk);
        stop_with_failure("watchdog expired before all rows were applied");
    end

endmodule

// File: tests/ekf_properties.sv
`timescale 1ns/10ps

module ekf_properties (
    input logic                  clk,
    input logic                  n_rst,
    input logic                  meas_req,
    input logic                  meas_ack,
    input logic                  result_req,
    input ekf_io_pkg::estimate_t result
);

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (!n_rst)
        (meas_ack && !$past(meas_ack)) |-> $past(meas_req))
        else $error("meas_ack rose without meas_req");

    // estimate frozen for the whole transfer
    result_held: assert property (@(posedge clk) disable iff (!n_rst)
        (result_req && $past(result_req)) |-> $stable(result))
        else $error("result changed while result_req was high");

    // --------------------
    // both handshakes quiet in and right after reset
    quiet_in_reset: assert property (@(posedge clk)
        !n_rst |-> (!meas_ack && !result_req))
        else $error("handshake output high during reset");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(n_rst) |-> (!meas_ack && !result_req))
        else $error("handshake output high right after reset");

endmodule

// File: source/ekf_top.sv
`timescale 1ns/10ps

module ekf_top (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  meas_req,
    input  ekf_io_pkg::meas_t     meas,
    output logic                  meas_ack,
    output logic                  result_req,
    output ekf_io_pkg::estimate_t result,
    input  logic                  result_ack
);
    import ekf_io_pkg::*;

    logic      ready;
    logic      take;
    logic      predict_en;
    logic      correct_en;
    logic      publish;
    logic      out_idle;
    meas_t     captured;
    pred_t     pred;
    estimate_t state;

    // --------------------
    // handshake side
    meas_port u_meas_port (
        .clk      (clk),
        .n_rst    (n_rst),
        .meas_req (meas_req),
        .meas     (meas),
        .meas_ack (meas_ack),
        .ready    (ready),
        .take     (take),
        .captured (captured)
    );

    ekf_sequencer u_sequencer (
        .clk        (clk),
        .n_rst      (n_rst),
        .take       (take),
        .out_idle   (out_idle),
        .ready      (ready),
        .predict_en (predict_en),
        .correct_en (correct_en),
        .publish    (publish)
    );

    // --------------------
    // estimator datapath
    ekf_predict u_predict (
        .clk        (clk),
        .n_rst      (n_rst),
        .predict_en (predict_en),
        .captured   (captured),
        .state      (state),
        .pred       (pred)
    );

    ekf_correct u_correct (
        .clk        (clk),
        .n_rst      (n_rst),
        .correct_en (correct_en),
        .captured   (captured),
        .pred       (pred),
        .state      (state)
    );

    result_port u_result_port (
        .clk        (clk),
        .n_rst      (n_rst),
        .publish    (publish),
        .state      (state),
        .result_req (result_req),
        .result     (result),
        .result_ack (result_ack),
        .idle       (out_idle)
    );

endmodule

// File: source/ekf_correct.sv
`timescale 1ns/10ps
`include "ekf_config.svh"

module ekf_correct (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  correct_en,
    input  ekf_io_pkg::meas_t     captured,
    input  ekf_io_pkg::pred_t     pred,
    output ekf_io_pkg::estimate_t state
);
    import ekf_fixed_pkg::*;

    localparam soc_t  k_soc = `EKF_K_SOC;
    localparam coef_t k_rc  = `EKF_K_RC;

    volt_t                      innov;
    logic signed [2*word_w-1:0] prod_soc;
    logic signed [2*word_w-1:0] prod_rc;
    soc_t                       soc_n;
    vrc_t                       vrc_n;

    // measured minus predicted terminal voltage
    assign innov = captured.v_t - pred.vt_hat;

    // --------------------
    // gain times innovation, then back to the state format
    assign prod_soc = k_soc * innov;
    assign prod_rc  = k_rc * innov;

    // both products carry the innovation's 20 fraction bits on top
    assign soc_n = pred.soc_p + soc_t'(prod_soc >>> volt_frac);
    assign vrc_n = pred.vrc_p + vrc_t'(prod_rc >>> volt_frac);

    // state registers, reset to a full cell
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state.soc <= `EKF_INIT_SOC;
            state.vrc <= `EKF_INIT_VRC;
        end else if (correct_en) begin
            state.soc <= soc_n;
            state.vrc <= vrc_n;
        end
    end

endmodule

// File: source/ekf_predict.sv
`timescale 1ns/10ps
`include "ekf_config.svh"

module ekf_predict (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  predict_en,
    input  ekf_io_pkg::meas_t     captured,
    input  ekf_io_pkg::estimate_t state,
    output ekf_io_pkg::pred_t     pred
);
    import ekf_fixed_pkg::*;

    localparam coef_set_t set_short = '{
        b_1:      `EKF_SET_SHORT_B1,
        b_2:      `EKF_SET_SHORT_B2,
        a_4:      `EKF_SET_SHORT_A4,
        r_series: `EKF_SET_SHORT_RSER
    };
    localparam coef_set_t set_long = '{
        b_1:      `EKF_SET_LONG_B1,
        b_2:      `EKF_SET_LONG_B2,
        a_4:      `EKF_SET_LONG_A4,
        r_series: `EKF_SET_LONG_RSER
    };

    soc_t                                soc_src;
    vrc_t                                vrc_src;
    logic signed [word_w-soc_frac-1:0]   soc_int;
    logic signed [word_w-soc_frac-1:0]   soc_p_int;
    coef_set_t                           coef;
    coef_t                               theta4;
    ocv_off_t                            theta5;
    logic signed [word_w+current_w-1:0]  prod_b1;
    logic signed [word_w+current_w-1:0]  prod_b2;
    logic signed [word_w+current_w-1:0]  prod_r;
    logic signed [2*word_w-1:0]          prod_a4;
    logic signed [2*word_w-1:0]          prod_th4;
    soc_t                                soc_p;
    vrc_t                                vrc_p;
    volt_t                               v_ocv;
    volt_t                               v_off;
    volt_t                               v_rc;
    volt_t                               v_ser;

    // restart from the initial state on an init measurement
    always_comb begin
        if (captured.init) begin
            soc_src = `EKF_INIT_SOC;
            vrc_src = `EKF_INIT_VRC;
        end else begin
            soc_src = state.soc;
            vrc_src = state.vrc;
        end
    end

    // --------------------
    // state prediction
    assign soc_int = soc_src[word_w-1:soc_frac];
    assign coef    = (soc_int < `EKF_SOC_SET_LIMIT) ? set_short : set_long;

    assign prod_b1 = coef.b_1 * captured.i_b;
    assign prod_b2 = coef.b_2 * captured.i_b;
    assign prod_a4 = coef.a_4 * vrc_src;

    assign soc_p = soc_src + soc_t'(prod_b1 >>> (coef_frac - soc_frac));
    assign vrc_p = vrc_t'(prod_a4 >>> coef_frac)
                 + vrc_t'(prod_b2 >>> (coef_frac - vrc_frac));

    // --------------------
    // ocv band from the predicted soc
    assign soc_p_int = soc_p[word_w-1:soc_frac];

    always_comb begin
        if (soc_p_int < `EKF_OCV_LOW) begin
            theta4 = `EKF_THETA4_LOW;
            theta5 = `EKF_THETA5_LOW;
        end else if (soc_p_int <= `EKF_OCV_HIGH) begin
            theta4 = `EKF_THETA4_MID;
            theta5 = `EKF_THETA5_MID;
        end else begin
            theta4 = `EKF_THETA4_HIGH;
            theta5 = `EKF_THETA5_HIGH;
        end
    end

    // terminal voltage terms, all brought to Q3.20
    assign prod_th4 = theta4 * soc_p;
    assign prod_r   = coef.r_series * captured.i_b;

    assign v_ocv = volt_t'(prod_th4 >>> (coef_frac + soc_frac - volt_frac));
    assign v_off = volt_t'(theta5 >>> (ocv_frac - volt_frac));
    assign v_rc  = volt_t'(vrc_p >>> (vrc_frac - volt_frac));
    assign v_ser = volt_t'(prod_r >>> (coef_frac - volt_frac));

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            pred <= '0;
        end else if (predict_en) begin
            pred.soc_p  <= soc_p;
            pred.vrc_p  <= vrc_p;
            pred.vt_hat <= v_ocv + v_off - v_rc - v_ser;
        end
    end

endmodule

// File: source/ekf_sequencer.sv
`timescale 1ns/10ps

module ekf_sequencer (
    input  logic clk,
    input  logic n_rst,
    input  logic take,
    input  logic out_idle,
    output logic ready,
    output logic predict_en,
    output logic correct_en,
    output logic publish
);

    typedef enum logic [1:0] {
        st_wait,
        st_predict,
        st_correct,
        st_publish
    } phase_t;

    phase_t phase;
    phase_t phase_n;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            phase <= st_wait;
        end else begin
            phase <= phase_n;
        end
    end

    // fixed three-cycle step once a measurement is taken
    always_comb begin
        case (phase)
            st_wait:    phase_n = take ? st_predict : st_wait;
            st_predict: phase_n = st_correct;
            st_correct: phase_n = st_publish;
            st_publish: phase_n = st_wait;
            default:    phase_n = st_wait;
        endcase
    end

    // no new capture while the last estimate is still out
    assign ready      = (phase == st_wait) && out_idle;
    assign predict_en = (phase == st_predict);
    assign correct_en = (phase == st_correct);
    assign publish    = (phase == st_publish);

endmodule

// File: source/result_port.sv
`timescale 1ns/10ps

module result_port (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  publish,
    input  ekf_io_pkg::estimate_t state,
    output logic                  result_req,
    output ekf_io_pkg::estimate_t result,
    input  logic                  result_ack,
    output logic                  idle
);

    // snapshot of the state, steady for the whole transfer
    always_ff @(posedge clk) begin
        if (publish) begin
            result <= state;
        end
    end

    // --------------------
    // sending half of the four-phase handshake
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            result_req <= 1'b0;
            idle       <= 1'b1;
        end else if (publish) begin
            result_req <= 1'b1;
            idle       <= 1'b0;
        end else if (result_req && result_ack) begin
            result_req <= 1'b0;
        end else if (!idle && !result_req && !result_ack) begin
            // sink has released ack, transfer closed
            idle <= 1'b1;
        end
    end

endmodule

// File: source/meas_port.sv
`timescale 1ns/10ps

module meas_port (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              meas_req,
    input  ekf_io_pkg::meas_t meas,
    output logic              meas_ack,
    input  logic              ready,
    output logic              take,
    output ekf_io_pkg::meas_t captured
);

    // new request, not yet acknowledged, and the estimator can start
    assign take = meas_req && !meas_ack && ready;

    // receiving half of the four-phase handshake
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            meas_ack <= 1'b0;
        end else if (take) begin
            meas_ack <= 1'b1;
        end else if (!meas_req) begin
            meas_ack <= 1'b0;
        end
    end

    // held until the next capture
    always_ff @(posedge clk) begin
        if (take) begin
            captured <= meas;
        end
    end

endmodule

// File: source/ekf_io_pkg.sv
package ekf_io_pkg;

    // one measurement, init restarts from the initial state
    typedef struct packed {
        logic                    init;
        ekf_fixed_pkg::current_t i_b;
        ekf_fixed_pkg::volt_t    v_t;
    } meas_t;

    // published estimate, also the state register
    typedef struct packed {
        ekf_fixed_pkg::soc_t soc;
        ekf_fixed_pkg::vrc_t vrc;
    } estimate_t;

    // prediction handed to the correction stage
    typedef struct packed {
        ekf_fixed_pkg::soc_t  soc_p;
        ekf_fixed_pkg::vrc_t  vrc_p;
        ekf_fixed_pkg::volt_t vt_hat;
    } pred_t;

endpackage

// File: source/ekf_fixed_pkg.sv
package ekf_fixed_pkg;

    // --------------------
    // word and fraction widths
    localparam int word_w    = 24;
    localparam int current_w = 5;

    localparam int soc_frac  = 16;
    localparam int vrc_frac  = 23;
    localparam int volt_frac = 20;
    localparam int coef_frac = 23;
    localparam int ocv_frac  = 21;

    // --------------------
    // number formats
    // soc in percent, Q7.16
    typedef logic signed [word_w-1:0] soc_t;
    // rc branch voltage, Q0.23
    typedef logic signed [word_w-1:0] vrc_t;
    // terminal voltage, Q3.20
    typedef logic signed [word_w-1:0] volt_t;
    typedef logic signed [word_w-1:0] coef_t;
    // ocv offset, Q2.21
    typedef logic signed [word_w-1:0] ocv_off_t;
    // whole amperes
    typedef logic signed [current_w-1:0] current_t;

    // model coefficients for one sample interval
    typedef struct packed {
        coef_t b_1;
        coef_t b_2;
        coef_t a_4;
        coef_t r_series;
    } coef_set_t;

endpackage

// File: source/ekf_config.svh
`ifndef EKF_CONFIG_SVH
`define EKF_CONFIG_SVH

// --------------------
// coefficient sets, Q0.23
// short interval, used below the set limit
`define EKF_SET_SHORT_B1   24'shFF463E
`define EKF_SET_SHORT_B2   24'sh00B729
`define EKF_SET_SHORT_A4   24'sh6AFF26
`define EKF_SET_SHORT_RSER 24'sh03EA03

// long interval
`define EKF_SET_LONG_B1    24'shF8BE67
`define EKF_SET_LONG_B2    24'sh0727A3
`define EKF_SET_LONG_A4    24'shADF77E
`define EKF_SET_LONG_RSER  24'sh0A5753

// --------------------
// band limits, integer percent
`define EKF_SOC_SET_LIMIT  32
`define EKF_OCV_LOW        20
`define EKF_OCV_HIGH       95

// ocv slope per band, Q0.23 volts per percent
`define EKF_THETA4_LOW     24'sh03645A
`define EKF_THETA4_MID     24'sh011D14
`define EKF_THETA4_HIGH    24'sh01FBE7

// ocv offset per band, Q2.21 volts
`define EKF_THETA5_LOW     24'sh5D2474
`define EKF_THETA5_MID     24'sh688659
`define EKF_THETA5_HIGH    24'sh53D3C3

// --------------------
// fixed gains, soc gain is Q7.16 percent per volt
`define EKF_K_SOC          24'sh020000
`define EKF_K_RC           24'sh080000

// state after reset or an init measurement
`define EKF_INIT_SOC       24'sh640000
`define EKF_INIT_VRC       24'sh000000

`endif
